//--- sim.f
src/fp_mul_pkg.sv
src/fp_unpack.sv
src/booth_multiplier.sv
src/fp_normalize_round.sv
src/fp_mul_top.sv
verif/fp_mul_assertions.sv
verif/fp_mul_tb.sv

//--- src/booth_multiplier.sv
// ==============================
// Radix-2 Booth multiplier
// Sequential signed multiply, one bit per cycle,
// one-hot step machine and a done pulse
// ==============================
`timescale 1ns/10ps
`default_nettype none

module booth_multiplier #(
    parameter int operand_width = 25
) (
    input  logic                       clk_sys,
    input  logic                       rst_sys_n,
    input  logic                       start,
    input  logic [operand_width-1:0]   mant_a,
    input  logic [operand_width-1:0]   mant_b,
    output logic [2*operand_width-3:0] product,
    output logic                       prod_done
);

    // Accumulator holds upper half, multiplier and guard bit
    localparam int acc_width = 2 * operand_width + 1;
    localparam int cnt_width = $clog2(operand_width + 1);

    // One-hot states
    localparam logic [3:0] st_idle   = 4'b0001;
    localparam logic [3:0] st_load   = 4'b0010;
    localparam logic [3:0] st_iter   = 4'b0100;
    localparam logic [3:0] st_finish = 4'b1000;

    logic [3:0]               state;
    logic [3:0]               state_nxt;
    logic                     start_q;
    logic [cnt_width-1:0]     step_cnt;
    logic                     step_last;
    logic [operand_width-1:0] mcand;
    logic [operand_width-1:0] mcand_neg;
    logic [acc_width-1:0]     acc;
    logic [operand_width-1:0] sum_add;
    logic [operand_width-1:0] sum_sub;

    assign step_last = (step_cnt == cnt_width'(operand_width));

    // ==============================
    // Step machine
    // ==============================
    // Registered start, one cycle before load
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start && (state == st_idle) && !start_q;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            st_idle:   state_nxt = start_q ? st_load : st_idle;
            st_load:   state_nxt = st_iter;
            st_iter:   state_nxt = step_last ? st_finish : st_iter;
            st_finish: state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
    end

    // Counts shift/add steps, stops at operand_width
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            step_cnt <= '0;
        end else if (state != st_iter) begin
            step_cnt <= '0;
        end else if (!step_last) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Pulse after one cycle in finish
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            prod_done <= 1'b0;
        end else begin
            prod_done <= (state == st_finish);
        end
    end

    // ==============================
    // Datapath
    // ==============================
    // Upper half plus or minus the multiplicand
    assign sum_add = acc[acc_width-1:operand_width+1] + mcand;
    assign sum_sub = acc[acc_width-1:operand_width+1] + mcand_neg;

    always_ff @(posedge clk_sys) begin
        if (state == st_load) begin
            mcand     <= mant_a;
            mcand_neg <= ~mant_a + 1'b1;
            // Multiplier in low half, zero guard bit below
            acc       <= {{operand_width{1'b0}}, mant_b, 1'b0};
        end else if ((state == st_iter) && !step_last) begin
            // Booth pair decides, then arithmetic shift right
            case (acc[1:0])
                2'b01:   acc <= {sum_add[operand_width-1], sum_add, acc[operand_width:1]};
                2'b10:   acc <= {sum_sub[operand_width-1], sum_sub, acc[operand_width:1]};
                default: acc <= {acc[acc_width-1], acc[acc_width-1:1]};
            endcase
        end
    end

    // Low product bits above the guard bit
    assign product = acc[2*operand_width-2:1];

endmodule

`default_nettype wire

//--- src/fp_mul_pkg.sv
// ==============================
// FP multiplier shared types
// Float word views, operand classes, status flags
// and single-precision format constants
// ==============================
`default_nettype none

package fp_mul_pkg;

    // ==============================
    // Format constants
    // ==============================
    localparam int unsigned exp_bias      = 127;
    localparam int unsigned frac_width    = 23;
    // Zero sign bit, hidden one, fraction
    localparam int unsigned mant_op_width = 25;
    localparam int unsigned product_width = 48;
    // Canonical quiet NaN
    localparam logic [31:0] qnan_word     = 32'h7fc0_0000;

    // ==============================
    // Float word
    // ==============================
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] fraction;
    } fp_fields_t;

    // Same 32 bits seen as a raw word or as IEEE fields
    typedef union packed {
        logic [31:0] raw;
        fp_fields_t  fields;
    } fp_word_u;

    // ==============================
    // Classification and status
    // ==============================
    // Zero also covers denormals, which are flushed
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_normal;
    } operand_class_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    // Unpack to normalize/round
    // Exponent sum is exp_a + exp_b - bias, signed
    typedef struct packed {
        logic              sign;
        logic signed [9:0] exp_sum;
        operand_class_t    class_a;
        operand_class_t    class_b;
    } mul_class_t;

endpackage

`default_nettype wire

//--- src/fp_mul_top.sv
// ==============================
// FP single-precision multiplier
// Unpack, Booth mantissa multiply, normalize/round
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fp_mul_top import fp_mul_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys_n,
    input  logic      start,
    input  fp_word_u  op_a,
    input  fp_word_u  op_b,
    output fp_word_u  result,
    output fp_flags_t flags,
    output logic      done
);

    logic [mant_op_width-1:0] mant_a;
    logic [mant_op_width-1:0] mant_b;
    mul_class_t               mul_info;
    logic [product_width-1:0] product;
    logic                     prod_done;

    // Operand capture and classification
    fp_unpack i_fp_unpack (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .start     (start),
        .op_a      (op_a),
        .op_b      (op_b),
        .prod_done (prod_done),
        .mant_a    (mant_a),
        .mant_b    (mant_b),
        .mul_info  (mul_info)
    );

    // Mantissa product
    booth_multiplier #(
        .operand_width (mant_op_width)
    ) i_booth_multiplier (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .start     (start),
        .mant_a    (mant_a),
        .mant_b    (mant_b),
        .product   (product),
        .prod_done (prod_done)
    );

    // Rounding, specials and result register
    fp_normalize_round i_fp_normalize_round (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .product   (product),
        .prod_done (prod_done),
        .mul_info  (mul_info),
        .result    (result),
        .flags     (flags),
        .done      (done)
    );

endmodule

`default_nettype wire

//--- src/fp_normalize_round.sv
// ==============================
// FP normalize and round
// Aligns the mantissa product, rounds to nearest-even,
// resolves special operands and registers the result
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fp_normalize_round import fp_mul_pkg::*; (
    input  logic                     clk_sys,
    input  logic                     rst_sys_n,
    input  logic [product_width-1:0] product,
    input  logic                     prod_done,
    input  mul_class_t               mul_info,
    output fp_word_u                 result,
    output fp_flags_t                flags,
    output logic                     done
);

    // Guard bit position after alignment
    localparam int grd_pos = product_width - frac_width - 2;

    logic                     norm_shift;
    logic [product_width-1:0] prod_al;
    logic [frac_width-1:0]    frac_norm;
    logic                     guard_bit;
    logic                     round_bit;
    logic                     sticky_bit;
    logic                     round_up;
    logic [frac_width:0]      frac_rnd;
    logic signed [9:0]        exp_norm;
    logic signed [9:0]        exp_final;
    logic                     any_nan;
    logic                     any_inf;
    logic                     any_zero;
    logic                     inf_zero;
    fp_word_u                 result_d;
    fp_flags_t                flags_d;

    // ==============================
    // Normalize
    // ==============================
    // Product of two 1.x mantissas lies in [1, 4)
    assign norm_shift = product[product_width-1];

    // Leading one ends up at the top bit
    assign prod_al = norm_shift ? product : {product[product_width-2:0], 1'b0};

    assign frac_norm  = prod_al[product_width-2 -: frac_width];
    assign guard_bit  = prod_al[grd_pos];
    assign round_bit  = prod_al[grd_pos-1];
    assign sticky_bit = |prod_al[grd_pos-2:0];

    assign exp_norm = mul_info.exp_sum + (norm_shift ? 10'sd1 : 10'sd0);

    // ==============================
    // Round to nearest-even
    // ==============================
    // Ties go up only on an odd lsb
    assign round_up = guard_bit && (round_bit || sticky_bit || frac_norm[0]);
    assign frac_rnd = {1'b0, frac_norm} + {{frac_width{1'b0}}, round_up};

    // Carry out means mantissa 10.0, fraction already zero
    assign exp_final = exp_norm + $signed({9'd0, frac_rnd[frac_width]});

    // Operand class summary
    assign any_nan  = mul_info.class_a.is_nan || mul_info.class_b.is_nan;
    assign any_inf  = mul_info.class_a.is_inf || mul_info.class_b.is_inf;
    assign any_zero = mul_info.class_a.is_zero || mul_info.class_b.is_zero;
    assign inf_zero = (mul_info.class_a.is_inf && mul_info.class_b.is_zero) ||
                      (mul_info.class_a.is_zero && mul_info.class_b.is_inf);

    // ==============================
    // Special cases in priority order
    // ==============================
    always_comb begin
        result_d             = '0;
        flags_d              = '0;
        result_d.fields.sign = mul_info.sign;
        if (any_nan || inf_zero) begin
            // Canonical quiet NaN, sign dropped
            result_d.raw    = qnan_word;
            flags_d.invalid = inf_zero;
        end else if (any_inf) begin
            result_d.fields.exponent = 8'hff;
        end else if (any_zero) begin
            // Signed zero
            result_d.fields.exponent = 8'h00;
        end else if (exp_final >= 10'sd255) begin
            // Overflow to signed infinity
            result_d.fields.exponent = 8'hff;
            flags_d.overflow         = 1'b1;
            flags_d.inexact          = 1'b1;
        end else if (exp_final <= 10'sd0) begin
            // Flush tiny results
            flags_d.underflow = 1'b1;
            flags_d.inexact   = 1'b1;
        end else begin
            result_d.fields.exponent = exp_final[7:0];
            result_d.fields.fraction = frac_rnd[frac_width-1:0];
            flags_d.inexact          = guard_bit || round_bit || sticky_bit;
        end
    end

    // ==============================
    // Output registers
    // ==============================
    // Result held until the next product completes
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else begin
            done <= prod_done;
            if (prod_done) begin
                result <= result_d;
                flags  <= flags_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/fp_unpack.sv
// ==============================
// FP operand unpack
// Latches both operands on start, classifies them,
// forms Booth mantissas and the biased exponent sum
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fp_unpack import fp_mul_pkg::*; (
    input  logic                     clk_sys,
    input  logic                     rst_sys_n,
    input  logic                     start,
    input  fp_word_u                 op_a,
    input  fp_word_u                 op_b,
    input  logic                     prod_done,
    output logic [mant_op_width-1:0] mant_a,
    output logic [mant_op_width-1:0] mant_b,
    output mul_class_t               mul_info
);

    logic           busy;
    logic           accept;
    operand_class_t class_a;
    operand_class_t class_b;
    logic [9:0]     exp_sum;

    // Class from exponent and fraction
    // Zero exponent is zero whatever the fraction
    function automatic operand_class_t classify(input fp_fields_t f);
        operand_class_t c;
        c.is_zero   = (f.exponent == 8'h00);
        c.is_inf    = (f.exponent == 8'hff) && (f.fraction == '0);
        c.is_nan    = (f.exponent == 8'hff) && (f.fraction != '0);
        c.is_normal = (f.exponent != 8'h00) && (f.exponent != 8'hff);
        return c;
    endfunction

    assign class_a = classify(op_a.fields);
    assign class_b = classify(op_b.fields);

    // Biased sum, wraps to negative for tiny products
    assign exp_sum = {2'b00, op_a.fields.exponent} + {2'b00, op_b.fields.exponent}
                   - 10'(exp_bias);

    // Accept when idle
    // A start in the prod_done cycle is also taken,
    // the Booth machine is idle again by then
    assign accept = start && (!busy || prod_done);

    // ==============================
    // Busy level
    // ==============================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (prod_done) begin
            busy <= 1'b0;
        end
    end

    // ==============================
    // Operand registers
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            // Top bit zero keeps Booth operands non-negative
            mant_a           <= {1'b0, op_a.fields.exponent != 8'h00, op_a.fields.fraction};
            mant_b           <= {1'b0, op_b.fields.exponent != 8'h00, op_b.fields.fraction};
            mul_info.sign    <= op_a.fields.sign ^ op_b.fields.sign;
            mul_info.exp_sum <= exp_sum;
            mul_info.class_a <= class_a;
            mul_info.class_b <= class_b;
        end
    end

endmodule

`default_nettype wire

//--- verif/fp_mul_assertions.sv
// ==============================
// FP multiplier protocol checks
// Done pulse shape and latency, reset state
// and special-result flag rules
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fp_mul_assertions import fp_mul_pkg::*; (
    input logic      clk_sys,
    input logic      rst_sys_n,
    input logic      start,
    input fp_word_u  result,
    input fp_flags_t flags,
    input logic      done
);

    localparam int latency = 30;

    int   assert_errors = 0;
    logic in_flight;
    logic accepted;

    // Start taken when idle or in the done cycle
    assign accepted = start && (!in_flight || done);

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            in_flight <= 1'b0;
        end else if (accepted) begin
            in_flight <= 1'b1;
        end else if (done) begin
            in_flight <= 1'b0;
        end
    end

    // ==============================
    // Done pulse
    // ==============================
    done_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        done |=> !done)
    else begin
        $error("done held high for more than one cycle");
        assert_errors++;
    end

    // Registered at the 30th edge after the start edge
    done_latency: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        accepted |=> !done [*latency] ##1 done)
    else begin
        $error("done not seen exactly %0d cycles after start", latency);
        assert_errors++;
    end

    // Outputs cleared once reset has been held across a clock edge
    reset_quiet: assert property (@(posedge clk_sys)
        !rst_sys_n ##1 !rst_sys_n |-> (!done && flags == '0 && result.raw == '0))
    else begin
        $error("outputs not cleared during reset");
        assert_errors++;
    end

    // ==============================
    // Special results
    // ==============================
    nan_no_overflow: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        done && result.fields.exponent == 8'hff && result.fields.fraction != '0
        |-> !flags.overflow)
    else begin
        $error("NaN result reported with overflow");
        assert_errors++;
    end

    invalid_gives_qnan: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        done && flags.invalid |-> result.raw == qnan_word)
    else begin
        $error("invalid flag without canonical quiet NaN");
        assert_errors++;
    end

endmodule

bind fp_mul_top fp_mul_assertions i_fp_mul_assertions (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_sys_n),
    .start     (start),
    .result    (result),
    .flags     (flags),
    .done      (done)
);

`default_nettype wire

//--- verif/fp_mul_tb.sv
// ==============================
// FP multiplier testbench
// Directed, special, busy and random operands
// checked against a double-precision model
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fp_mul_tb import fp_mul_pkg::*; ();

    localparam int num_dir     = 20;
    localparam int num_rand    = 200;
    localparam int num_tests   = num_dir + num_rand + 1;
    localparam int cycle_limit = num_tests * 40 + 100;
    localparam int latency     = 30;

    // Exact, rounding, specials, overflow, underflow
    localparam logic [31:0] dir_a [num_dir] = '{
        32'h3fc00000, 32'hc0400000, 32'h40e00000, 32'h3f800003,
        32'h3fc00001, 32'h3ffffffe, 32'h3dcccccd, 32'h7f800001,
        32'h80000000, 32'h7f800000, 32'h80000000, 32'h7f800000,
        32'hff800000, 32'h00000123, 32'h00400000, 32'h7f000000,
        32'hff7fffff, 32'h7f7fffff, 32'h00800000, 32'h80800000
    };
    localparam logic [31:0] dir_b [num_dir] = '{
        32'h40000000, 32'h3f000000, 32'hbfa00000, 32'h3fc00000,
        32'h3fc00000, 32'h3f800001, 32'h40400000, 32'h3f800000,
        32'hc0e00000, 32'h00000000, 32'hff800000, 32'hc0000000,
        32'hff800000, 32'hc0400000, 32'h7f800000, 32'h40000000,
        32'h7f7fffff, 32'h3f800000, 32'h3f000000, 32'h00800000
    };

    logic        clk_sys;
    logic        rst_sys_n;
    logic        start;
    fp_word_u    op_a;
    fp_word_u    op_b;
    fp_word_u    result;
    fp_flags_t   flags;
    logic        done;
    logic [31:0] rand_a;
    logic [31:0] rand_b;
    int          cycle_cnt;
    int          err_cnt;
    int          test_cnt;
    int          bad_tests;
    int          sva_errs;

    fp_mul_top i_fp_mul_top (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .start     (start),
        .op_a      (op_a),
        .op_b      (op_b),
        .result    (result),
        .flags     (flags),
        .done      (done)
    );

    always #10 clk_sys = ~clk_sys;

    // Run limit
    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, done never arrived", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ==============================
    // Reference model
    // ==============================
    // Exact double view of a normal single
    function automatic real to_double(input fp_word_u w);
        return $bitstoreal({w.fields.sign, 11'(w.fields.exponent) + 11'd896,
                            w.fields.fraction, 29'd0});
    endfunction

    function automatic void model_mul(input fp_word_u a, input fp_word_u b,
                                      output fp_word_u res, output fp_flags_t flg);
        logic        zero_a;
        logic        zero_b;
        logic        inf_a;
        logic        inf_b;
        logic        nan_any;
        logic [63:0] dbits;
        logic [23:0] frac_r;
        int          exp_r;
        res = '0;
        flg = '0;
        res.fields.sign = a.fields.sign ^ b.fields.sign;
        zero_a  = a.fields.exponent == 8'h00;
        zero_b  = b.fields.exponent == 8'h00;
        inf_a   = a.fields.exponent == 8'hff && a.fields.fraction == '0;
        inf_b   = b.fields.exponent == 8'hff && b.fields.fraction == '0;
        nan_any = (a.fields.exponent == 8'hff && !inf_a) || (b.fields.exponent == 8'hff && !inf_b);
        if (nan_any || (inf_a && zero_b) || (zero_a && inf_b)) begin
            res.raw     = qnan_word;
            flg.invalid = (inf_a && zero_b) || (zero_a && inf_b);
        end else if (inf_a || inf_b) begin
            res.fields.exponent = 8'hff;
        end else if (!(zero_a || zero_b)) begin
            // Double product is exact, 48 significant bits at most
            dbits  = $realtobits(to_double(a) * to_double(b));
            exp_r  = int'(dbits[62:52]) - 896;
            frac_r = {1'b0, dbits[51:29]};
            // Nearest-even on the 29 dropped bits
            if (dbits[28] && (dbits[27:0] != '0 || dbits[29])) begin
                frac_r = frac_r + 24'd1;
            end
            if (frac_r[23]) begin
                exp_r = exp_r + 1;
            end
            if (exp_r >= 255) begin
                res.fields.exponent = 8'hff;
                flg.overflow        = 1'b1;
                flg.inexact         = 1'b1;
            end else if (exp_r <= 0) begin
                flg.underflow = 1'b1;
                flg.inexact   = 1'b1;
            end else begin
                res.fields.exponent = exp_r[7:0];
                res.fields.fraction = frac_r[22:0];
                flg.inexact         = dbits[28:0] != '0;
            end
        end
    endfunction

    // Normal operand, product stays in normal range
    function automatic logic [31:0] rand_normal();
        fp_fields_t f;
        f.sign     = 1'($urandom);
        f.exponent = 8'(64 + $urandom % 126);
        f.fraction = 23'($urandom);
        return f;
    endfunction

    // ==============================
    // Checks and test sequences
    // ==============================
    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v)
        else begin
            $display("FAILED %s expected %h got %h", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string kind, input logic [31:0] a,
                               input logic [31:0] b, input int errs_before);
        test_cnt++;
        if (err_cnt != errs_before) begin
            bad_tests++;
        end
        $display("test %0d %s a=%h b=%h result=%h flags=%h %s", test_cnt, kind, a, b,
                 result.raw, flags, (err_cnt == errs_before) ? "ok" : "mismatch");
    endtask

    // One start pulse, wait for done, compare
    task automatic run_one(input logic [31:0] a, input logic [31:0] b, input string kind);
        fp_word_u  exp_res;
        fp_flags_t exp_flg;
        int        cycles;
        int        errs_before;
        errs_before = err_cnt;
        model_mul(a, b, exp_res, exp_flg);
        op_a.raw = a;
        op_b.raw = b;
        start    = 1'b1;
        @(negedge clk_sys);
        start  = 1'b0;
        cycles = 0;
        while (!done) begin
            @(negedge clk_sys);
            cycles++;
        end
        check_value("result", exp_res.raw, result.raw);
        check_value("flags", 32'(exp_flg), 32'(flags));
        check_value("latency", latency, cycles);
        report_test(kind, a, b, errs_before);
    endtask

    // Second start mid-multiply must be dropped
    task automatic run_busy();
        fp_word_u  exp_res;
        fp_flags_t exp_flg;
        int        errs_before;
        int        extra;
        errs_before = err_cnt;
        model_mul(32'h40400000, 32'h40a00000, exp_res, exp_flg);
        op_a.raw = 32'h40400000;
        op_b.raw = 32'h40a00000;
        start    = 1'b1;
        @(negedge clk_sys);
        start = 1'b0;
        repeat (10) @(negedge clk_sys);
        op_a.raw = 32'hc1200000;
        op_b.raw = 32'h3e800000;
        start    = 1'b1;
        @(negedge clk_sys);
        start = 1'b0;
        while (!done) begin
            @(negedge clk_sys);
        end
        check_value("result", exp_res.raw, result.raw);
        check_value("flags", 32'(exp_flg), 32'(flags));
        extra = 0;
        repeat (40) begin
            @(negedge clk_sys);
            if (done) begin
                extra++;
            end
        end
        assert (extra == 0)
        else begin
            $display("Start while busy produced %0d extra done pulses", extra);
            err_cnt++;
        end
        report_test("busy", 32'h40400000, 32'h40a00000, errs_before);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk_sys   = 1'b0;
        rst_sys_n = 1'b0;
        start     = 1'b0;
        op_a      = '0;
        op_b      = '0;
        cycle_cnt = 0;
        err_cnt   = 0;
        test_cnt  = 0;
        bad_tests = 0;
        void'($urandom(32'hc90664e9));
        repeat (4) @(negedge clk_sys);
        rst_sys_n = 1'b1;
        @(negedge clk_sys);
        for (int i = 0; i < num_dir; i++) begin
            run_one(dir_a[i], dir_b[i], "directed");
            @(negedge clk_sys);
        end
        run_busy();
        for (int i = 0; i < num_rand; i++) begin
            rand_a = rand_normal();
            rand_b = rand_normal();
            run_one(rand_a, rand_b, "random");
            @(negedge clk_sys);
        end
        sva_errs = i_fp_mul_top.i_fp_mul_assertions.assert_errors;
        $display("Tests %0d, failed %0d, check errors %0d, assertion errors %0d",
                 test_cnt, bad_tests, err_cnt, sva_errs);
        if (err_cnt == 0 && sva_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
